// File: list.f
icache_pkg.sv
icache_tag_ram.sv
icache_data_ram.sv
icache_replacement.sv
icache_refill_ctrl.sv
icache.sv
icache_props.sv
tb_icache.sv

// File: Makefile
# Verilator flow for the instruction cache testbench
VERILATOR ?= verilator
TOP       ?= tb_icache
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert --timescale 1ns/100ps
FAIL_MSG  ?= Some tests failed
PASS_MSG  ?= All tests passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation FAILED, run stopped early"; exit 1; fi
	@echo "simulation PASSED"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_icache.sv
module tb_icache;
    timeunit 1ns;
    timeprecision 100ps;

    import icache_pkg::*;

    localparam int    CLK_PERIOD   = 20;
    localparam int    DRIVE_DELAY  = 2;
    localparam int    NUM_RANDOM   = 600;
    localparam int    NUM_LINES    = 320;              // random footprint in lines
    localparam int    NUM_REQUESTS = NUM_RANDOM + 16;
    localparam int    MISS_CYCLES  = 40;               // worst refill plus idle gap
    localparam int    TIMEOUT_NS   = NUM_REQUESTS * MISS_CYCLES * CLK_PERIOD + 2000;
    localparam addr_t RAND_BASE    = 32'h0080_0000;

    logic  clk;
    logic  rst_n;
    addr_t instr_addr;
    logic  cpu_req;
    logic  cpu_addr_ok;
    logic  cpu_data_ok;
    word_t instr_rdata;
    logic  mem_req;
    addr_t mem_read_addr;
    word_t mem_read_data;
    logic  mem_addr_ok;
    logic  mem_data_ok;

    int    seed = 60486;
    int    cycle = 0;
    int    errors = 0;
    int    checks = 0;
    int    tests_run = 0;
    string test_name = "none";
    int    test_err_start;
    int    test_reqs;

    // the one outstanding request
    logic  req_open = 1'b0;
    logic  exp_hit;
    word_t exp_word;
    addr_t exp_addr;
    int    start_cycle;
    logic  last_hit;

    addr_t pending_addr [$];   // accepted but data not yet returned
    addr_t issued [$];         // accepted during the current request

    // reference model state
    tag_t  m_tag [NUM_WAYS][NUM_SETS];
    bit    m_valid [NUM_WAYS][NUM_SETS];
    bit    m_ptr [NUM_SETS];

    icache u_icache (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_addr    (instr_addr),
        .cpu_req       (cpu_req),
        .cpu_addr_ok   (cpu_addr_ok),
        .cpu_data_ok   (cpu_data_ok),
        .instr_rdata   (instr_rdata),
        .mem_req       (mem_req),
        .mem_read_addr (mem_read_addr),
        .mem_read_data (mem_read_data),
        .mem_addr_ok   (mem_addr_ok),
        .mem_data_ok   (mem_data_ok)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    // memory contents as a fixed mix of the whole address
    function automatic word_t mem_word(input addr_t a);
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h5a5a_c3c3;
    endfunction

    // predicts hit or miss and applies the fill to the model
    function automatic logic model_access(input addr_t a);
        tag_t   t;
        index_t s;
        logic   hit;
        t   = a[ADDR_WIDTH-1 -: TAG_WIDTH];
        s   = a[OFFSET_WIDTH +: INDEX_WIDTH];
        hit = 1'b0;
        for (int w = 0; w < NUM_WAYS; w++)
        begin
            if (m_valid[w][s] && (m_tag[w][s] == t))
            begin
                hit = 1'b1;
            end
        end
        if (!hit)
        begin
            m_tag[m_ptr[s]][s]   = t;     // victim is the round-robin pointer
            m_valid[m_ptr[s]][s] = 1'b1;
            m_ptr[s]             = ~m_ptr[s];
        end
        return hit;
    endfunction

    task automatic check_equal(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected)
        else
        begin
            $display("FAIL %s: %s expected %h, actual %h", test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic fetch(input addr_t a);
        @(posedge clk);
        #DRIVE_DELAY;
        exp_hit     = model_access(a);
        exp_word    = mem_word(a);
        exp_addr    = a;
        start_cycle = cycle;
        req_open    = 1'b1;
        cpu_req     = 1'b1;
        instr_addr  = a;
        test_reqs++;
        wait (!req_open);
    endtask

    task automatic release_req();
        @(posedge clk);
        #DRIVE_DELAY;
        cpu_req = 1'b0;
    endtask

    task automatic begin_test(input string name);
        test_name      = name;
        test_err_start = errors;
        test_reqs      = 0;
    endtask

    task automatic end_test();
        release_req();
        tests_run++;
        $display("test %s done: %0d requests, %0d errors",
                 test_name, test_reqs, errors - test_err_start);
    endtask

    // memory side decides at negedge and drives after the rising edge
    initial
    begin : mem_responder
        int    addr_wait;
        int    data_wait;
        logic  next_addr_ok;
        logic  next_data_ok;
        word_t next_data;
        addr_t ret_addr;
        mem_addr_ok   = 1'b0;
        mem_data_ok   = 1'b0;
        mem_read_data = '0;
        addr_wait     = 0;
        data_wait     = 0;
        next_data     = '0;
        forever
        begin
            @(negedge clk);
            if (mem_req && mem_addr_ok)   // accepted at the coming edge
            begin
                pending_addr.push_back(mem_read_addr);
                issued.push_back(mem_read_addr);
                addr_wait = {$random(seed)} % 4;
            end
            else if (mem_req && (addr_wait > 0))
            begin
                addr_wait--;
            end
            if (mem_data_ok)
            begin
                data_wait = {$random(seed)} % 4;
            end
            else if ((pending_addr.size() > 0) && (data_wait > 0))
            begin
                data_wait--;
            end
            next_addr_ok = (addr_wait == 0);
            next_data_ok = 1'b0;
            if ((pending_addr.size() > 0) && (data_wait == 0))
            begin
                ret_addr     = pending_addr.pop_front();   // in request order
                next_data    = mem_word(ret_addr);
                next_data_ok = 1'b1;
            end
            @(posedge clk);
            #DRIVE_DELAY;
            mem_addr_ok   = next_addr_ok;
            mem_data_ok   = next_data_ok;
            mem_read_data = next_data;
        end
    end

    // compares every completed request against the model
    initial
    begin : compare
        addr_t line_base;
        int    n_exp;
        logic  act_hit;
        forever
        begin
            @(negedge clk);
            if (cpu_data_ok)
            begin
                checks++;
                assert (req_open)
                else
                begin
                    $display("cpu_data_ok went high with no request outstanding");
                    errors++;
                end
                act_hit = (cycle == start_cycle);   // answered in the first cycle
                check_equal("hit", 32'(exp_hit), 32'(act_hit));
                check_equal("data", exp_word, instr_rdata);
                check_equal("cpu_addr_ok", 32'd1, 32'(cpu_addr_ok));
                n_exp = exp_hit ? 0 : WORDS_PER_LINE;
                check_equal("refill address count", n_exp, issued.size());
                line_base = {exp_addr[ADDR_WIDTH-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};
                for (int i = 0; (i < issued.size()) && (i < WORDS_PER_LINE); i++)
                begin
                    check_equal("refill address", line_base + addr_t'(4 * i), issued[i]);
                end
                issued.delete();
                last_hit = act_hit;
                req_open = 1'b0;
            end
        end
    end

    initial
    begin : watchdog
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns, a request never completed", TIMEOUT_NS);
        $display("Some tests failed");
        $finish;
    end

    initial
    begin : main
        addr_t a;
        int    line_no;
        int    woff;
        rst_n      = 1'b0;
        cpu_req    = 1'b0;
        instr_addr = '0;
        repeat (2) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;

        begin_test("reset");
        @(negedge clk);
        check_equal("outputs after reset", 32'd0, 32'({mem_req, cpu_addr_ok, cpu_data_ok}));
        fetch(32'h0000_0100);
        check_equal("first request hit", 32'd0, 32'(last_hit));
        end_test();

        begin_test("cold_miss");
        fetch(32'h0010_0238);
        check_equal("cold request hit", 32'd0, 32'(last_hit));
        end_test();

        begin_test("line_hits");   // rest of the line just filled
        for (int i = 0; i < WORDS_PER_LINE; i++)
        begin
            fetch(32'h0010_0230 + addr_t'(4 * i));
            check_equal("filled line hit", 32'd1, 32'(last_hit));
        end
        end_test();

        begin_test("eviction");    // three tags on the same index
        fetch(32'h0020_0050);
        fetch(32'h0030_0050);
        fetch(32'h0040_0050);      // replaces way 0
        fetch(32'h0020_0050);
        check_equal("evicted line hit", 32'd0, 32'(last_hit));
        fetch(32'h0040_0050);
        check_equal("surviving line hit", 32'd1, 32'(last_hit));
        end_test();

        begin_test("random");
        for (int n = 0; n < NUM_RANDOM; n++)
        begin
            line_no = {$random(seed)} % NUM_LINES;
            woff    = {$random(seed)} % WORDS_PER_LINE;
            a       = RAND_BASE + addr_t'(line_no * 16) + addr_t'(woff * 4);
            fetch(a);
            if (({$random(seed)} % 4) == 0)
            begin
                release_req();   // idle cycle between requests
            end
        end
        end_test();

        repeat (4) @(posedge clk);
        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0)
        begin
            $display("All tests passed");
        end
        else
        begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: icache_props.sv
module icache_props (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cpu_req,
    input  logic               cpu_data_ok,
    input  logic               mem_req,
    input  icache_pkg::addr_t  mem_read_addr,
    input  logic               mem_addr_ok,
    input  logic               mem_data_ok
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned addr_cnt;   // accepted memory addresses
    int unsigned data_cnt;   // returned memory words

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            addr_cnt <= 0;
            data_cnt <= 0;
        end
        else
        begin
            if (mem_req && mem_addr_ok)
            begin
                addr_cnt <= addr_cnt + 1;
            end
            if (mem_data_ok)
            begin
                data_cnt <= data_cnt + 1;
            end
        end
    end

    // a pending memory request holds until accepted
    a_mem_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_req && !mem_addr_ok) |=> (mem_req && $stable(mem_read_addr)))
        else $error("memory request dropped or address changed before mem_addr_ok");

    // a hit answers only while no refill is running
    a_cpu_ok: assert property (@(posedge clk) disable iff (!rst_n)
        cpu_data_ok |-> (cpu_req && !mem_req))
        else $error("cpu_data_ok without cpu_req or during a refill");

    // data never runs ahead of accepted addresses
    a_data_after_addr: assert property (@(posedge clk) disable iff (!rst_n)
        mem_data_ok |-> (data_cnt < addr_cnt))
        else $error("mem_data_ok with no accepted address outstanding");

endmodule

bind icache icache_props u_icache_props (
    .clk           (clk),
    .rst_n         (rst_n),
    .cpu_req       (cpu_req),
    .cpu_data_ok   (cpu_data_ok),
    .mem_req       (mem_req),
    .mem_read_addr (mem_read_addr),
    .mem_addr_ok   (mem_addr_ok),
    .mem_data_ok   (mem_data_ok)
);

// File: icache.sv
module icache (
    input  logic               clk,
    input  logic               rst_n,
    input  icache_pkg::addr_t  instr_addr,
    input  logic               cpu_req,
    output logic               cpu_addr_ok,
    output logic               cpu_data_ok,
    output icache_pkg::word_t  instr_rdata,
    output logic               mem_req,
    output icache_pkg::addr_t  mem_read_addr,
    input  icache_pkg::word_t  mem_read_data,
    input  logic               mem_addr_ok,
    input  logic               mem_data_ok
);
    import icache_pkg::*;

    tag_t   req_tag;
    index_t req_index;
    woff_t  req_woff;

    logic [NUM_WAYS-1:0] way_valid;
    logic [NUM_WAYS-1:0] way_hit;
    logic [NUM_WAYS-1:0] way_wr;
    tag_t                way_tag  [NUM_WAYS];
    line_t               way_line [NUM_WAYS];

    way_t  hit_way;
    way_t  victim;
    line_t sel_line;
    logic  hit;
    logic  miss;
    logic  fill_en;
    line_t fill_line;
    woff_t addr_woff;

    // address split, the fetch unit holds instr_addr until accepted
    assign req_tag   = instr_addr[ADDR_WIDTH-1 -: TAG_WIDTH];
    assign req_index = instr_addr[OFFSET_WIDTH +: INDEX_WIDTH];
    assign req_woff  = instr_addr[2 +: OFFSET_WIDTH-2];

    for (genvar w = 0; w < NUM_WAYS; w++)
    begin : g_way
        assign way_wr[w] = fill_en && (victim == way_t'(w));  // only the victim way fills

        icache_tag_ram u_tag_ram (
            .clk      (clk),
            .rst_n    (rst_n),
            .rd_index (req_index),
            .rd_valid (way_valid[w]),
            .rd_tag   (way_tag[w]),
            .wr_en    (way_wr[w]),
            .wr_index (req_index),
            .wr_tag   (req_tag)
        );

        icache_data_ram u_data_ram (
            .clk      (clk),
            .rd_index (req_index),
            .rd_line  (way_line[w]),
            .wr_en    (way_wr[w]),
            .wr_index (req_index),
            .wr_line  (fill_line)
        );

        assign way_hit[w] = way_valid[w] && (way_tag[w] == req_tag);
    end

    always_comb
    begin
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++)
        begin
            if (way_hit[w])
            begin
                hit_way = way_t'(w);
            end
        end
    end

    assign hit      = |way_hit;
    assign sel_line = way_line[hit_way];

    always_comb
    begin
        instr_rdata = '0;
        for (int i = 0; i < WORDS_PER_LINE; i++)
        begin
            if (woff_t'(i) == req_woff)
            begin
                instr_rdata = sel_line[i*32 +: 32];
            end
        end
    end

    // a hit completes in the request cycle
    assign cpu_addr_ok = cpu_req && hit;
    assign cpu_data_ok = cpu_req && hit;
    assign miss        = cpu_req && !hit;

    icache_replacement u_replacement (
        .clk     (clk),
        .rst_n   (rst_n),
        .index   (req_index),
        .fill_en (fill_en),
        .victim  (victim)
    );

    icache_refill_ctrl u_refill_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .miss          (miss),
        .mem_addr_ok   (mem_addr_ok),
        .mem_data_ok   (mem_data_ok),
        .mem_read_data (mem_read_data),
        .mem_req       (mem_req),
        .addr_woff     (addr_woff),
        .fill_en       (fill_en),
        .fill_line     (fill_line)
    );

    assign mem_read_addr = {req_tag, req_index, addr_woff, 2'b00};  // word aligned line fetch

endmodule

// File: icache_refill_ctrl.sv
module icache_refill_ctrl (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               miss,
    input  logic               mem_addr_ok,
    input  logic               mem_data_ok,
    input  icache_pkg::word_t  mem_read_data,
    output logic               mem_req,
    output icache_pkg::woff_t  addr_woff,
    output logic               fill_en,
    output icache_pkg::line_t  fill_line
);
    import icache_pkg::*;

    refill_state_t state, state_next;

    woff_t addr_cnt;    // next word address to issue
    logic  addr_done;   // all line addresses accepted
    woff_t data_cnt;    // words returned so far
    line_t line_buf;

    // addresses keep going while data lags behind
    assign mem_req   = (state == RF_FETCH) && !addr_done;
    assign addr_woff = addr_cnt;
    assign fill_en   = (state == RF_FILL);
    assign fill_line = line_buf;

    always_comb
    begin
        state_next = state;
        case (state)
            RF_IDLE:
            begin
                if (miss)
                begin
                    state_next = RF_FETCH;
                end
            end
            RF_FETCH:
            begin
                if (mem_data_ok && (data_cnt == '1))   // last word of the line
                begin
                    state_next = RF_FILL;
                end
            end
            default: state_next = RF_IDLE;   // RF_FILL lasts one cycle
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state     <= RF_IDLE;
            addr_cnt  <= '0;
            addr_done <= 1'b0;
            data_cnt  <= '0;
        end
        else
        begin
            state <= state_next;
            if (state == RF_IDLE)
            begin
                addr_cnt  <= '0;
                addr_done <= 1'b0;
                data_cnt  <= '0;
            end
            else if (state == RF_FETCH)
            begin
                if (mem_req && mem_addr_ok)
                begin
                    addr_cnt  <= addr_cnt + 1'b1;
                    addr_done <= (addr_cnt == '1);
                end
                if (mem_data_ok)
                begin
                    data_cnt <= data_cnt + 1'b1;
                end
            end
        end
    end

    // words arrive in order, shift in from the top so word 0 ends up lowest
    always_ff @(posedge clk)
    begin
        if ((state == RF_FETCH) && mem_data_ok)
        begin
            line_buf <= {mem_read_data, line_buf[$bits(line_t)-1:$bits(word_t)]};
        end
    end

endmodule

// File: icache_replacement.sv
module icache_replacement (
    input  logic                clk,
    input  logic                rst_n,
    input  icache_pkg::index_t  index,
    input  logic                fill_en,
    output icache_pkg::way_t    victim
);
    import icache_pkg::*;

    logic [NUM_SETS-1:0] ptr;   // one round-robin bit per set

    assign victim = way_t'(ptr[index]);

    // the fill writes the current victim, the pointer moves on at the same edge
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ptr <= '0;
        end
        else if (fill_en)
        begin
            ptr[index] <= ~ptr[index];
        end
    end

endmodule

// File: icache_data_ram.sv
module icache_data_ram (
    input  logic                clk,
    input  icache_pkg::index_t  rd_index,
    output icache_pkg::line_t   rd_line,
    input  logic                wr_en,
    input  icache_pkg::index_t  wr_index,
    input  icache_pkg::line_t   wr_line
);
    import icache_pkg::*;

    line_t lines [NUM_SETS];

    // asynchronous read of the whole line
    assign rd_line = lines[rd_index];

    // whole line written at once on a fill
    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            lines[wr_index] <= wr_line;
        end
    end

endmodule

// File: icache_tag_ram.sv
module icache_tag_ram (
    input  logic                clk,
    input  logic                rst_n,
    input  icache_pkg::index_t  rd_index,
    output logic                rd_valid,
    output icache_pkg::tag_t    rd_tag,
    input  logic                wr_en,
    input  icache_pkg::index_t  wr_index,
    input  icache_pkg::tag_t    wr_tag
);
    import icache_pkg::*;

    logic [NUM_SETS-1:0] valid;
    tag_t                tags [NUM_SETS];

    // lookup is combinational so a hit can answer in the request cycle
    assign rd_valid = valid[rd_index];
    assign rd_tag   = tags[rd_index];

    // valid bits come up clear, a fill marks its set valid
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            valid <= '0;
        end
        else if (wr_en)
        begin
            valid[wr_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            tags[wr_index] <= wr_tag;  // written together with the valid bit
        end
    end

endmodule

// File: icache_pkg.sv
package icache_pkg;

    // address geometry
    localparam int ADDR_WIDTH     = 32;
    localparam int OFFSET_WIDTH   = 4;                     // byte offset within a line
    localparam int WORDS_PER_LINE = 2 ** (OFFSET_WIDTH - 2);
    localparam int INDEX_WIDTH    = 6;
    localparam int NUM_SETS       = 2 ** INDEX_WIDTH;
    localparam int TAG_WIDTH      = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

    // associativity
    localparam int NUM_WAYS = 2;

    typedef logic [ADDR_WIDTH-1:0]          addr_t;
    typedef logic [31:0]                    word_t;
    typedef logic [TAG_WIDTH-1:0]           tag_t;
    typedef logic [INDEX_WIDTH-1:0]         index_t;
    typedef logic [OFFSET_WIDTH-3:0]        woff_t;   // word offset within a line
    typedef logic [WORDS_PER_LINE*32-1:0]   line_t;   // word 0 sits in the low bits
    typedef logic [$clog2(NUM_WAYS)-1:0]    way_t;

    // refill controller states
    typedef enum logic [1:0] {
        RF_IDLE,    // nothing outstanding
        RF_FETCH,   // issuing word addresses and collecting data
        RF_FILL     // single cycle line write
    } refill_state_t;

endpackage
